//--- src.f
source/drr_pkg.sv
source/drr_rank_pipe.sv
source/drr_divider.sv
source/drr_flow_state.sv
source/drr_csr_axil.sv
source/drr_rank_top.sv
tb/drr_tb_asserts.sv
tb/drr_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the DRR rank testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module drr_tb \
    -o drr_sim > build.log 2>&1 \
    && ./obj_dir/drr_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

//--- tb/drr_tb.sv
`timescale 1ns/100ps

module drr_tb import drr_pkg::*;
();

    logic                   clk_cp;
    logic                   rst;
    logic                   pkt_valid;
    pkt_desc_t              pkt;
    dq_fb_t [num_ports-1:0] dq_fb;
    axil_req_t              axil_req;
    axil_rsp_t              axil_rsp;
    logic                   rank_valid;
    rank_t                  rank;

    // Model pipeline slot, one per edge of packet latency
    typedef struct packed {
        logic      v;
        flow_id_t  flow;
        pkt_size_t size;
        quantum_t  quant;
    } slot_t;

    logic [31:0] lfsr = 32'h789c_71b7;
    int          err_count;
    int          timeout_count;
    quantum_t    m_quant  [num_flows];
    round_t      m_round  [num_flows];
    quantum_t    m_remain [num_flows];
    slot_t       slots    [5];
    logic        exp_valid;
    rank_t       exp_rank;

    drr_rank_top dut0 (
        .clk_cp       (clk_cp),
        .rst          (rst),
        .pkt_valid_i  (pkt_valid),
        .pkt_i        (pkt),
        .dq_fb_i      (dq_fb),
        .axil_req_i   (axil_req),
        .axil_rsp_o   (axil_rsp),
        .rank_valid_o (rank_valid),
        .rank_o       (rank)
    );

    always #5 clk_cp = ~clk_cp;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic flow_id_t decode_flow(input pkt_desc_t p);
        port_id_t port;
        port = '0;
        for (int i = num_ports - 1; i >= 0; i--)
        begin
            if (p.mask[i])
                port = port_id_t'(i);
        end
        return {port, p.tclass};
    endfunction

    function automatic axil_addr_t csr_addr(input logic [1:0] field, input flow_id_t flow);
        return {field, flow, 2'b00};
    endfunction

    task automatic report_mismatch(input string name, input longint exp, input longint act);
        $display("ERROR %s expected %0h actual %0h", name, exp, act);
        err_count++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timeout_count++;
    endtask

    //////////////////////////////////////////////////
    // Reference model, stepped on every rising edge
    //////////////////////////////////////////////////
    always @(posedge clk_cp)
    begin
        pkt_size_t q;
        quantum_t  r;
        dq_fb_t    fb;
        flow_id_t  fl;
        if (!rst)
        begin
            for (int f = 0; f < num_flows; f++)
            begin
                m_quant[f]  = 17'd1500;
                m_round[f]  = '0;
                m_remain[f] = '0;
            end
            for (int k = 0; k < 5; k++)
                slots[k] = '0;
            exp_valid = 1'b0;
        end
        else
        begin
            for (int f = 0; f < num_flows; f++)
            begin
                fb = dq_fb[f / num_classes];
                if (fb.valid && fb.round > m_round[f])
                begin
                    m_round[f]  = fb.round;
                    m_remain[f] = m_quant[f];      // Refill from current quantum
                end
            end
            exp_valid = slots[4].v;
            if (slots[4].v)
            begin
                fl = slots[4].flow;
                q  = pkt_size_t'(slots[4].size / slots[4].quant);
                r  = quantum_t'(slots[4].size % slots[4].quant);
                if (m_remain[fl] < r)
                begin
                    m_remain[fl] = m_remain[fl] + slots[4].quant - r;
                    m_round[fl]  = m_round[fl] + round_t'(q) + 17'd1;
                end
                else
                begin
                    m_remain[fl] = m_remain[fl] - r;
                    m_round[fl]  = m_round[fl] + round_t'(q);
                end
                exp_rank = '{flow: fl, round: m_round[fl]};
            end
            for (int k = 4; k >= 2; k--)
                slots[k] = slots[k-1];
            slots[1]       = slots[0];
            slots[1].quant = m_quant[slots[0].flow];  // Quantum frozen one edge after sample
            slots[0]       = '{v: pkt_valid, flow: decode_flow(pkt), size: pkt.size, quant: '0};
            // Accepted quantum writes land last
            if (axil_rsp.awready && axil_rsp.wready && axil_req.awvalid && axil_req.wvalid &&
                axil_req.awaddr[8:7] == 2'd0 && axil_req.wdata[16:0] != '0)
                m_quant[axil_req.awaddr[6:2]] = axil_req.wdata[16:0];
        end
    end

    // Rank output checked mid-cycle
    always @(negedge clk_cp)
    begin
        if (rst)
        begin
            assert (rank_valid == exp_valid)
            else report_mismatch("rank_valid", exp_valid, rank_valid);
            if (exp_valid)
            begin
                assert (rank == exp_rank)
                else report_mismatch("rank", exp_rank, rank);
            end
        end
    end

    //////////////////////////////////////////////////
    // AXI4-Lite access
    //////////////////////////////////////////////////
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_resp_t exp_resp);
        int         cnt;
        int         delay;
        axil_resp_t resp;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        cnt = 0;
        while (!(axil_rsp.awready && axil_rsp.wready) && cnt < 100)
        begin
            @(negedge clk_cp);
            cnt++;
        end
        if (cnt >= 100)
            report_timeout("write accept");
        @(negedge clk_cp);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        cnt = 0;
        while (!axil_rsp.bvalid && cnt < 100)
        begin
            @(negedge clk_cp);
            cnt++;
        end
        if (cnt >= 100)
            report_timeout("write response");
        resp  = axil_rsp.bresp;
        delay = int'(rand_bits(2));
        repeat (delay)
        begin
            @(negedge clk_cp);
            assert (axil_rsp.bvalid)
            else report_mismatch("bvalid hold", 1, axil_rsp.bvalid);
            assert (axil_rsp.bresp == resp)
            else report_mismatch("bresp hold", resp, axil_rsp.bresp);
        end
        assert (resp == exp_resp)
        else report_mismatch("bresp", exp_resp, resp);
        axil_req.bready = 1'b1;
        @(negedge clk_cp);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, input axil_data_t exp_data,
                             input axil_resp_t exp_resp, input string name);
        int         cnt;
        int         delay;
        axil_data_t data;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        cnt = 0;
        while (!axil_rsp.arready && cnt < 100)
        begin
            @(negedge clk_cp);
            cnt++;
        end
        if (cnt >= 100)
            report_timeout("read accept");
        @(negedge clk_cp);
        axil_req.arvalid = 1'b0;
        cnt = 0;
        while (!axil_rsp.rvalid && cnt < 100)
        begin
            @(negedge clk_cp);
            cnt++;
        end
        if (cnt >= 100)
            report_timeout("read data");
        data  = axil_rsp.rdata;
        delay = int'(rand_bits(2));
        repeat (delay)
        begin
            @(negedge clk_cp);
            assert (axil_rsp.rvalid)
            else report_mismatch("rvalid hold", 1, axil_rsp.rvalid);
            assert (axil_rsp.rdata == data)
            else report_mismatch("rdata hold", data, axil_rsp.rdata);
        end
        assert (axil_rsp.rresp == exp_resp)
        else report_mismatch({name, " rresp"}, exp_resp, axil_rsp.rresp);
        if (exp_resp == resp_okay)
        begin
            assert (data == exp_data)
            else report_mismatch(name, exp_data, data);
        end
        axil_req.rready = 1'b1;
        @(negedge clk_cp);
        axil_req.rready = 1'b0;
    endtask

    task automatic check_all_flows();
        for (int f = 0; f < num_flows; f++)
        begin
            axil_read(csr_addr(2'd1, flow_id_t'(f)), axil_data_t'(m_round[f]), resp_okay, "round");
            axil_read(csr_addr(2'd2, flow_id_t'(f)), axil_data_t'(m_remain[f]), resp_okay,
                      "remain");
        end
    endtask

    // Packets each cycle, optionally pinned to one flow, optionally with feedback
    task automatic run_traffic(input int cycles, input int pin_flow, input logic use_fb);
        for (int c = 0; c < cycles; c++)
        begin
            pkt_valid  = (pin_flow >= 0) ? 1'b1 : 1'(rand_bits(1));
            pkt.mask   = port_mask_t'(rand_bits(4));
            pkt.tclass = class_t'(rand_bits(3));
            pkt.size   = pkt_size_t'(rand_bits(11));
            if (pin_flow >= 0)
            begin
                pkt.mask   = port_mask_t'(1 << (pin_flow / num_classes));
                pkt.tclass = class_t'(pin_flow % num_classes);
            end
            for (int p = 0; p < num_ports; p++)
            begin
                dq_fb[p].valid = use_fb && rand_bits(2) == 0;
                dq_fb[p].round = round_t'(rand_bits(7));
            end
            @(negedge clk_cp);
        end
        pkt_valid = 1'b0;
        dq_fb     = '0;
        repeat (8) @(negedge clk_cp);
    endtask

    initial
    begin
        quantum_t qv;
        flow_id_t fl;
        clk_cp        = 1'b0;
        rst           = 1'b0;
        pkt_valid     = 1'b0;
        pkt           = '0;
        dq_fb         = '0;
        axil_req      = '0;
        err_count     = 0;
        timeout_count = 0;
        repeat (4) @(negedge clk_cp);
        rst = 1'b1;
        @(negedge clk_cp);

        // Reset values
        for (int f = 0; f < num_flows; f++)
        begin
            axil_read(csr_addr(2'd0, flow_id_t'(f)), 32'd1500, resp_okay, "reset quantum");
            axil_read(csr_addr(2'd1, flow_id_t'(f)), 32'd0, resp_okay, "reset round");
        end

        // Quantum writes and refused accesses
        for (int i = 0; i < 40; i++)
        begin
            fl = flow_id_t'(rand_bits(5));
            qv = quantum_t'(rand_bits(10)) + 17'd1;
            axil_write(csr_addr(2'd0, fl), axil_data_t'(qv), resp_okay);
            axil_read(csr_addr(2'd0, fl), axil_data_t'(qv), resp_okay, "quantum");
        end
        fl = flow_id_t'(rand_bits(5));
        axil_write(csr_addr(2'd0, fl), 32'd0, resp_slverr);
        axil_read(csr_addr(2'd0, fl), axil_data_t'(m_quant[fl]), resp_okay, "zero write");
        axil_write(csr_addr(2'd1, fl), 32'd77, resp_slverr);
        axil_read(csr_addr(2'd1, fl), 32'd0, resp_okay, "round write");
        axil_read(csr_addr(2'd0, fl), axil_data_t'(m_quant[fl]), resp_okay,
                  "round write quantum");
        axil_read(csr_addr(2'd3, fl), 32'd0, resp_slverr, "field 3");

        run_traffic(300, -1, 1'b0);
        check_all_flows();
        run_traffic(12, int'(rand_bits(5)), 1'b0);
        check_all_flows();
        run_traffic(300, -1, 1'b1);
        check_all_flows();

        $display("Checks failed: %0d, timeouts: %0d, assertion failures: %0d",
                 err_count, timeout_count, dut0.asserts0.fail_count);
        if (err_count == 0 && timeout_count == 0 && dut0.asserts0.fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb/drr_tb_asserts.sv
`timescale 1ns/100ps

module drr_tb_asserts import drr_pkg::*;
(
    input logic      clk_cp,
    input logic      rst,
    input axil_req_t axil_req_i,
    input axil_rsp_t axil_rsp_o,
    input logic      rank_valid_o
);

    int fail_count = 0;

    //////////////////////////////////////////////////
    // Quiet outputs after a reset edge
    //////////////////////////////////////////////////
    quiet_after_reset: assert property (@(posedge clk_cp)
        !rst |=> (!rank_valid_o && !axil_rsp_o.bvalid && !axil_rsp_o.rvalid &&
                  !axil_rsp_o.awready && !axil_rsp_o.wready && !axil_rsp_o.arready))
    else
    begin
        $error("Outputs active right after a reset edge");
        fail_count++;
    end

    // Write response holds until taken
    bvalid_holds: assert property (@(posedge clk_cp) disable iff (!rst)
        axil_rsp_o.bvalid && !axil_req_i.bready |=>
            axil_rsp_o.bvalid && $stable(axil_rsp_o.bresp))
    else
    begin
        $error("Write response changed before bready");
        fail_count++;
    end

    rvalid_holds: assert property (@(posedge clk_cp) disable iff (!rst)
        axil_rsp_o.rvalid && !axil_req_i.rready |=>
            axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata) && $stable(axil_rsp_o.rresp))
    else
    begin
        $error("Read data changed before rready");
        fail_count++;
    end

endmodule

bind drr_rank_top drr_tb_asserts asserts0 (.*);

//--- source/drr_rank_top.sv
`timescale 1ns/100ps

module drr_rank_top import drr_pkg::*;
(
    input  logic                   clk_cp,
    input  logic                   rst,
    input  logic                   pkt_valid_i,
    input  pkt_desc_t              pkt_i,
    input  dq_fb_t [num_ports-1:0] dq_fb_i,
    input  axil_req_t              axil_req_i,
    output axil_rsp_t              axil_rsp_o,
    output logic                   rank_valid_o,
    output rank_t                  rank_o
);

    flow_id_t                  quantum_flow;
    quantum_t                  pipe_quantum;
    logic                      div_valid;
    pkt_size_t                 div_size;
    quantum_t                  div_quantum;
    logic                      upd_valid;
    flow_id_t                  upd_flow;
    quantum_t                  upd_quantum;
    logic                      quo_valid;
    pkt_size_t                 quotient;
    quantum_t                  remainder;
    quantum_t [num_flows-1:0]  quantum_table;
    flow_id_t                  rd_flow;
    round_t                    rd_round;
    quantum_t                  rd_remain;

    drr_rank_pipe pipe0 (
        .clk_cp          (clk_cp),
        .rst             (rst),
        .pkt_valid_i     (pkt_valid_i),
        .pkt_i           (pkt_i),
        .quantum_i       (pipe_quantum),
        .quantum_flow_o  (quantum_flow),
        .div_valid_o     (div_valid),
        .div_size_o      (div_size),
        .div_quantum_o   (div_quantum),
        .upd_valid_o     (upd_valid),
        .upd_flow_o      (upd_flow),
        .upd_quantum_o   (upd_quantum)
    );

    drr_divider div0 (
        .clk_cp      (clk_cp),
        .rst         (rst),
        .valid_i     (div_valid),
        .dividend_i  (div_size),
        .divisor_i   (div_quantum),
        .valid_o     (quo_valid),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    drr_flow_state state0 (
        .clk_cp          (clk_cp),
        .rst             (rst),
        .dq_fb_i         (dq_fb_i),
        .upd_valid_i     (upd_valid & quo_valid), // Both lines carry the same token
        .upd_flow_i      (upd_flow),
        .upd_quantum_i   (upd_quantum),
        .quotient_i      (quotient),
        .remainder_i     (remainder),
        .quantum_table_i (quantum_table),
        .rd_flow_i       (rd_flow),
        .rank_valid_o    (rank_valid_o),
        .rank_o          (rank_o),
        .rd_round_o      (rd_round),
        .rd_remain_o     (rd_remain)
    );

    drr_csr_axil csr0 (
        .clk_cp          (clk_cp),
        .rst             (rst),
        .axil_req_i      (axil_req_i),
        .axil_rsp_o      (axil_rsp_o),
        .pipe_flow_i     (quantum_flow),
        .pipe_quantum_o  (pipe_quantum),
        .quantum_table_o (quantum_table),
        .rd_flow_o       (rd_flow),
        .rd_round_i      (rd_round),
        .rd_remain_i     (rd_remain)
    );

endmodule

//--- source/drr_csr_axil.sv
`timescale 1ns/100ps

module drr_csr_axil import drr_pkg::*;
(
    input  logic                     clk_cp,
    input  logic                     rst,
    input  axil_req_t                axil_req_i,
    output axil_rsp_t                axil_rsp_o,
    input  flow_id_t                 pipe_flow_i,
    output quantum_t                 pipe_quantum_o,
    output quantum_t [num_flows-1:0] quantum_table_o,
    output flow_id_t                 rd_flow_o,
    input  round_t                   rd_round_i,
    input  quantum_t                 rd_remain_i
);

    quantum_t [num_flows-1:0] quantum_q;
    logic       wr_ready_q;           // Drives both awready and wready
    logic       bvalid_q;
    axil_resp_t bresp_q;
    logic       ar_ready_q;
    logic       rvalid_q;
    axil_data_t rdata_q;
    axil_resp_t rresp_q;

    csr_field_t wr_field;
    flow_id_t   wr_flow;
    quantum_t   wr_quantum;
    logic       wr_ok;
    logic       wr_hs;
    csr_field_t rd_field;
    logic       rd_hs;
    axil_data_t rd_data;
    axil_resp_t rd_resp;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////
    assign wr_field   = csr_field_t'(axil_req_i.awaddr[addr_field_lsb +: $bits(csr_field_t)]);
    assign wr_flow    = axil_req_i.awaddr[addr_flow_lsb +: $bits(flow_id_t)];
    assign wr_quantum = quantum_t'(axil_req_i.wdata);

    // Only quantum is writable, and zero would break the divider
    assign wr_ok = (wr_field == field_quantum) && (wr_quantum != '0);
    assign wr_hs = wr_ready_q && axil_req_i.awvalid && axil_req_i.wvalid;

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            quantum_q  <= {num_flows{default_quantum}};
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
        end
        else
        begin
            // One-cycle ready pulse, held off while a response is pending
            wr_ready_q <= axil_req_i.awvalid && axil_req_i.wvalid && !wr_ready_q && !bvalid_q;
            if (wr_hs)
                bvalid_q <= 1'b1;
            else if (axil_req_i.bready)
                bvalid_q <= 1'b0;
            if (wr_hs && wr_ok)
                quantum_q[wr_flow] <= wr_quantum;
        end
    end

    always_ff @(posedge clk_cp)
    begin
        if (wr_hs)
            bresp_q <= wr_ok ? resp_okay : resp_slverr;
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////
    assign rd_field  = csr_field_t'(axil_req_i.araddr[addr_field_lsb +: $bits(csr_field_t)]);
    assign rd_flow_o = axil_req_i.araddr[addr_flow_lsb +: $bits(flow_id_t)];
    assign rd_hs     = ar_ready_q && axil_req_i.arvalid;

    always_comb
    begin
        rd_resp = resp_okay;
        case (rd_field)
            field_quantum: rd_data = axil_data_t'(quantum_q[rd_flow_o]);
            field_round:   rd_data = axil_data_t'(rd_round_i);
            field_remain:  rd_data = axil_data_t'(rd_remain_i);
            default:
            begin
                rd_data = '0;             // Field 3 is unmapped
                rd_resp = resp_slverr;
            end
        endcase
    end

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            ar_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end
        else
        begin
            ar_ready_q <= axil_req_i.arvalid && !ar_ready_q && !rvalid_q;
            if (rd_hs)
                rvalid_q <= 1'b1;
            else if (axil_req_i.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_cp)
    begin
        if (rd_hs)
        begin
            rdata_q <= rd_data;           // Snapshot at accept
            rresp_q <= rd_resp;
        end
    end

    assign axil_rsp_o = '{
        awready: wr_ready_q,
        wready:  wr_ready_q,
        bvalid:  bvalid_q,
        bresp:   bresp_q,
        arready: ar_ready_q,
        rvalid:  rvalid_q,
        rdata:   rdata_q,
        rresp:   rresp_q
    };

    assign pipe_quantum_o  = quantum_q[pipe_flow_i];
    assign quantum_table_o = quantum_q;

endmodule

//--- source/drr_flow_state.sv
`timescale 1ns/100ps

module drr_flow_state import drr_pkg::*;
(
    input  logic                     clk_cp,
    input  logic                     rst,
    input  dq_fb_t [num_ports-1:0]   dq_fb_i,
    input  logic                     upd_valid_i,
    input  flow_id_t                 upd_flow_i,
    input  quantum_t                 upd_quantum_i,
    input  pkt_size_t                quotient_i,
    input  quantum_t                 remainder_i,
    input  quantum_t [num_flows-1:0] quantum_table_i,
    input  flow_id_t                 rd_flow_i,
    output logic                     rank_valid_o,
    output rank_t                    rank_o,
    output round_t                   rd_round_o,
    output quantum_t                 rd_remain_o
);

    round_t   round_q  [num_flows];
    quantum_t remain_q [num_flows];
    round_t   round_n  [num_flows];
    quantum_t remain_n [num_flows];
    logic     rank_valid_q;
    rank_t    rank_q;

    //////////////////////////////////////////////////
    // Catch-up first, then the DRR charge
    //////////////////////////////////////////////////
    always_comb
    begin
        dq_fb_t   fb;
        round_t   rnd;
        quantum_t rem;
        for (int f = 0; f < num_flows; f++)
        begin
            fb  = dq_fb_i[f / num_classes];   // Port of this flow
            rnd = round_q[f];
            rem = remain_q[f];

            // Lagging flow jumps to the dequeued round with a full quantum
            if (fb.valid && fb.round > rnd)
            begin
                rnd = fb.round;
                rem = quantum_table_i[f];
            end

            if (upd_valid_i && upd_flow_i == flow_id_t'(f))
            begin
                if (rem < remainder_i)
                begin
                    // Borrow one more round of credit
                    rem = rem + upd_quantum_i - remainder_i;
                    rnd = rnd + round_t'(quotient_i) + round_t'(1);
                end
                else
                begin
                    rem = rem - remainder_i;
                    rnd = rnd + round_t'(quotient_i);
                end
            end

            round_n[f]  = rnd;
            remain_n[f] = rem;
        end
    end

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            round_q      <= '{default: '0};
            remain_q     <= '{default: '0};
            rank_valid_q <= 1'b0;
        end
        else
        begin
            round_q      <= round_n;
            remain_q     <= remain_n;
            rank_valid_q <= upd_valid_i;
        end
    end

    always_ff @(posedge clk_cp)
    begin
        rank_q <= '{flow: upd_flow_i, round: round_n[upd_flow_i]};  // Rank is the new round
    end

    assign rank_valid_o = rank_valid_q;
    assign rank_o       = rank_q;

    // CPU read port
    assign rd_round_o  = round_q[rd_flow_i];
    assign rd_remain_o = remain_q[rd_flow_i];

endmodule

//--- source/drr_divider.sv
`timescale 1ns/100ps

module drr_divider import drr_pkg::*;
(
    input  logic      clk_cp,
    input  logic      rst,
    input  logic      valid_i,
    input  pkt_size_t dividend_i,
    input  quantum_t  divisor_i,
    output logic      valid_o,
    output pkt_size_t quotient_o,
    output quantum_t  remainder_o
);

    localparam int dvd_bits = $bits(pkt_size_t);

    // Dividend bits shift out of dq as quotient bits shift in
    typedef struct packed {
        quantum_t  divisor;
        quantum_t  rem;
        pkt_size_t dq;
    } div_work_t;

    logic      valid_q [div_latency];
    div_work_t work_q  [div_latency];

    for (genvar s = 0; s < div_latency; s++)
    begin : g_stage
        localparam int bit_lo = (s * dvd_bits) / div_latency;
        localparam int bit_hi = ((s + 1) * dvd_bits) / div_latency;

        logic      v_in;
        div_work_t w_in;
        div_work_t w_out;

        if (s == 0)
        begin : g_src
            assign v_in = valid_i;
            assign w_in = '{divisor: divisor_i, rem: '0, dq: dividend_i};
        end
        else
        begin : g_src
            assign v_in = valid_q[s-1];
            assign w_in = work_q[s-1];
        end

        // Restoring steps for this stage's share of quotient bits
        always_comb
        begin
            logic [$bits(quantum_t):0] trial;
            w_out = w_in;
            for (int i = bit_lo; i < bit_hi; i++)
            begin
                trial    = {w_out.rem, w_out.dq[dvd_bits-1]};
                w_out.dq = w_out.dq << 1;
                if (trial >= {1'b0, w_out.divisor})
                begin
                    trial       = trial - {1'b0, w_out.divisor};
                    w_out.dq[0] = 1'b1;
                end
                w_out.rem = quantum_t'(trial); // Below divisor after the step
            end
        end

        always_ff @(posedge clk_cp)
        begin
            if (!rst)
                valid_q[s] <= 1'b0;
            else
                valid_q[s] <= v_in;
        end

        always_ff @(posedge clk_cp)
        begin
            if (v_in)
                work_q[s] <= w_out;
        end
    end

    assign valid_o     = valid_q[div_latency-1];
    assign quotient_o  = work_q[div_latency-1].dq;
    assign remainder_o = work_q[div_latency-1].rem;

endmodule

//--- source/drr_rank_pipe.sv
`timescale 1ns/100ps

module drr_rank_pipe import drr_pkg::*;
(
    input  logic      clk_cp,
    input  logic      rst,
    input  logic      pkt_valid_i,
    input  pkt_desc_t pkt_i,
    input  quantum_t  quantum_i,
    output flow_id_t  quantum_flow_o,
    output logic      div_valid_o,
    output pkt_size_t div_size_o,
    output quantum_t  div_quantum_o,
    output logic      upd_valid_o,
    output flow_id_t  upd_flow_o,
    output quantum_t  upd_quantum_o
);

    logic      in_valid_q;
    pkt_desc_t in_pkt_q;
    port_id_t  in_port;
    flow_id_t  in_flow;
    logic      s0_valid_q;
    flow_id_t  s0_flow_q;
    pkt_size_t s0_size_q;
    quantum_t  s0_quantum_q;
    logic      valid_sr   [div_latency];
    flow_id_t  flow_sr    [div_latency];
    quantum_t  quantum_sr [div_latency];

    // Lowest set bit wins, empty mask stays on port 0
    always_comb
    begin
        in_port = '0;
        for (int p = num_ports - 1; p >= 0; p--)
        begin
            if (in_pkt_q.mask[p])
                in_port = port_id_t'(p);
        end
    end

    assign in_flow        = {in_port, in_pkt_q.tclass};
    assign quantum_flow_o = in_flow;          // Table lookup in the csr

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            in_valid_q <= 1'b0;
            s0_valid_q <= 1'b0;
            valid_sr   <= '{default: 1'b0};
        end
        else
        begin
            in_valid_q <= pkt_valid_i;
            s0_valid_q <= in_valid_q;
            valid_sr[0] <= s0_valid_q;
            for (int i = 1; i < div_latency; i++)
                valid_sr[i] <= valid_sr[i-1];
        end
    end

    //////////////////////////////////////////////////
    // Payload follows its valid bit
    //////////////////////////////////////////////////
    always_ff @(posedge clk_cp)
    begin
        in_pkt_q      <= pkt_i;
        s0_flow_q     <= in_flow;
        s0_size_q     <= in_pkt_q.size;
        s0_quantum_q  <= quantum_i;       // Quantum frozen for this packet
        flow_sr[0]    <= s0_flow_q;
        quantum_sr[0] <= s0_quantum_q;
        for (int i = 1; i < div_latency; i++)
        begin
            flow_sr[i]    <= flow_sr[i-1];
            quantum_sr[i] <= quantum_sr[i-1];
        end
    end

    assign div_valid_o   = s0_valid_q;
    assign div_size_o    = s0_size_q;
    assign div_quantum_o = s0_quantum_q;

    // Lines up with the divider output
    assign upd_valid_o   = valid_sr[div_latency-1];
    assign upd_flow_o    = flow_sr[div_latency-1];
    assign upd_quantum_o = quantum_sr[div_latency-1];

endmodule

//--- source/drr_pkg.sv
package drr_pkg;

    //////////////////////////////////////////////////
    // Sizes and pipeline depth
    //////////////////////////////////////////////////
    localparam int num_ports   = 4;
    localparam int num_classes = 8;
    localparam int num_flows   = num_ports * num_classes;
    localparam int div_latency = 3;                      // Registered divider stages

    typedef logic [$clog2(num_ports)-1:0]   port_id_t;
    typedef logic [$clog2(num_classes)-1:0] class_t;
    typedef logic [$clog2(num_flows)-1:0]   flow_id_t;   // {port, class}
    typedef logic [num_ports-1:0]           port_mask_t; // One-hot input port
    typedef logic [10:0]                    pkt_size_t;  // Bytes
    typedef logic [16:0]                    quantum_t;   // Bytes per round
    typedef logic [16:0]                    round_t;     // Wraps modulo 2^17

    localparam quantum_t default_quantum = 17'd1500;

    // Packet descriptor from the match-action pipeline
    typedef struct packed {
        port_mask_t mask;
        class_t     tclass;
        pkt_size_t  size;
    } pkt_desc_t;

    // Last dequeued round, one per port
    typedef struct packed {
        logic   valid;
        round_t round;
    } dq_fb_t;

    typedef struct packed {
        flow_id_t flow;
        round_t   round;
    } rank_t;

    //////////////////////////////////////////////////
    // CPU register access
    //////////////////////////////////////////////////
    typedef logic [8:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'd0;
    localparam axil_resp_t resp_slverr = 2'd2;

    // Address layout {field, flow, 2'b00}
    localparam int addr_flow_lsb  = 2;
    localparam int addr_field_lsb = addr_flow_lsb + $bits(flow_id_t);

    typedef enum logic [1:0] {
        field_quantum = 2'd0,
        field_round   = 2'd1,
        field_remain  = 2'd2
    } csr_field_t;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage
